/* logic/itlb_config.svh */
`ifndef ITLB_CONFIG_SVH
`define ITLB_CONFIG_SVH

// Instruction TLB sizing for an Sv39 core

// Number of fully associative entries
// Kept small so eviction is reached after a handful of refills
`define ITLB_ENTRIES 4

// Sv39 virtual page number
// 39-bit virtual address minus the 12-bit page offset
`define ITLB_VPN_W 27

// Sv39 physical page number
// 56-bit physical address minus the 12-bit page offset
`define ITLB_PPN_W 44

`endif

/* logic/vm_pkg.sv */
`default_nettype none

`include "itlb_config.svh"

// Address types of the virtual memory system
package vm_pkg;

  // Virtual page number, three 9-bit Sv39 levels
  typedef logic [`ITLB_VPN_W-1:0] vpn_t;

  // Physical page number
  typedef logic [`ITLB_PPN_W-1:0] ppn_t;

endpackage

`default_nettype wire

/* logic/itlb_pkg.sv */
`default_nettype none

`include "itlb_config.svh"

// Bookkeeping types of the instruction TLB
package itlb_pkg;

  // One bit per entry
  // Used for valid, hit, user and replacement vectors
  typedef logic [`ITLB_ENTRIES-1:0] way_vec_t;

  // Encoded entry index
  typedef logic [$clog2(`ITLB_ENTRIES)-1:0] way_idx_t;

endpackage

`default_nettype wire

/* logic/itlb_entry_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itlb_config.svh"

// Storage of the TLB translations
// One tag, one PPN and one user bit per entry, plus a valid bit
module itlb_entry_array (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Refill from the page-table walker
  input  logic               refill_valid_i,
  input  vm_pkg::vpn_t       refill_vpn_i,
  input  vm_pkg::ppn_t       refill_ppn_i,
  input  logic               refill_user_i,
  // One-hot slot chosen by the replacement block
  input  itlb_pkg::way_vec_t refill_way_i,
  // Invalidate every entry
  input  logic               flush_i,
  // Entry contents toward the lookup
  output vm_pkg::vpn_t       tag_o [`ITLB_ENTRIES],
  output vm_pkg::ppn_t       ppn_o [`ITLB_ENTRIES],
  output itlb_pkg::way_vec_t user_o,
  output itlb_pkg::way_vec_t valid_o
);

  vm_pkg::vpn_t       tag_q [`ITLB_ENTRIES];
  vm_pkg::ppn_t       ppn_q [`ITLB_ENTRIES];
  itlb_pkg::way_vec_t user_q;
  itlb_pkg::way_vec_t valid_q;
  // Per-entry write enable
  itlb_pkg::way_vec_t write_en;

  // Only the selected slot is written on a refill
  assign write_en = refill_valid_i ? refill_way_i : '0;

  // Translation payload
  // Contents only matter once the valid bit is set
  for (genvar k = 0; k < `ITLB_ENTRIES; k++) begin : gen_entry
    always_ff @(posedge clk_i) begin
      if (write_en[k]) begin
        tag_q[k]  <= refill_vpn_i;
        ppn_q[k]  <= refill_ppn_i;
        user_q[k] <= refill_user_i;
      end
    end
  end

  // Valid bits
  // Flush has priority over a refill in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (refill_valid_i) begin
      valid_q <= valid_q | write_en;
    end
  end

  // Registered contents go straight to the lookup logic
  assign tag_o   = tag_q;
  assign ppn_o   = ppn_q;
  assign user_o  = user_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

/* logic/itlb_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itlb_config.svh"

// Fully associative lookup
// Compares the request against all entries in one cycle
module itlb_lookup (
  // Request from the fetch stage
  input  logic               req_valid_i,
  input  vm_pkg::vpn_t       req_vpn_i,
  // Entry contents
  input  vm_pkg::vpn_t       tag_i [`ITLB_ENTRIES],
  input  vm_pkg::ppn_t       ppn_i [`ITLB_ENTRIES],
  input  itlb_pkg::way_vec_t user_i,
  input  itlb_pkg::way_vec_t valid_i,
  // Per-entry match, one-hot or zero
  output itlb_pkg::way_vec_t hit_vec_o,
  // Translation result
  output logic               hit_o,
  output vm_pkg::ppn_t       ppn_o,
  output logic               user_o
);

  itlb_pkg::way_vec_t match_vec;

  // Tag compare on every entry
  // A VPN is never held twice, so at most one bit is set
  always_comb begin
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      match_vec[k] = req_valid_i && valid_i[k] && (tag_i[k] == req_vpn_i);
    end
  end

  assign hit_vec_o = match_vec;

  // Any match is a hit
  // Low whenever there is no request
  assign hit_o = |match_vec;

  // AND-OR mux over the entries
  // Everything stays zero on a miss
  always_comb begin
    ppn_o  = '0;
    user_o = 1'b0;
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      ppn_o  = ppn_o | (ppn_i[k] & {`ITLB_PPN_W{match_vec[k]}});
      user_o = user_o | (user_i[k] & match_vec[k]);
    end
  end

endmodule

`default_nettype wire

/* logic/itlb_replacement_block.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itlb_config.svh"

// NRU replacement for the instruction TLB
// Invalid entries are filled first, lowest index wins
// With all entries valid, the lowest entry not recently used is chosen
module itlb_replacement_block #(
  parameter int N = `ITLB_ENTRIES
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Valid bits of the entry array
  input  itlb_pkg::way_vec_t itlb_valid_vec_i,
  // Lookup activity, drives the used bits
  input  logic               itlb_req_valid_i,
  input  itlb_pkg::way_vec_t itlb_hit_vec_i,
  input  logic               itlb_hit_i,
  // One-hot slot for the next refill
  output itlb_pkg::way_vec_t itlb_replacement_vec_o
);

  // Recently used marks, called safe here
  itlb_pkg::way_vec_t safe_q;
  itlb_pkg::way_vec_t unsafe_vec;
  itlb_pkg::way_vec_t invalid_vec;
  itlb_pkg::way_idx_t unsafe_idx;
  itlb_pkg::way_idx_t invalid_idx;
  itlb_pkg::way_vec_t unsafe_oh;
  itlb_pkg::way_vec_t invalid_oh;
  logic               access_hit;
  logic               last_unsafe;
  logic               hit_on_last_unsafe;
  itlb_pkg::way_vec_t safe_en;

  // Index of the lowest set bit, zero when none is set
  function automatic itlb_pkg::way_idx_t lowest_set(input itlb_pkg::way_vec_t vec);
    itlb_pkg::way_idx_t idx;
    idx = '0;
    for (int k = N - 1; k >= 0; k--) begin
      if (vec[k]) begin
        idx = itlb_pkg::way_idx_t'(k);
      end
    end
    return idx;
  endfunction

  assign unsafe_vec  = ~safe_q;
  assign invalid_vec = ~itlb_valid_vec_i;

  // Priority encode, then back to one-hot
  assign unsafe_idx  = lowest_set(unsafe_vec);
  assign invalid_idx = lowest_set(invalid_vec);
  assign unsafe_oh   = itlb_pkg::way_vec_t'(1) << unsafe_idx;
  assign invalid_oh  = itlb_pkg::way_vec_t'(1) << invalid_idx;

  // Marks change only on a lookup hit
  assign access_hit = itlb_req_valid_i && itlb_hit_i;

  // A single unmarked entry left, and this hit lands on it
  assign last_unsafe        = (unsafe_oh == unsafe_vec);
  assign hit_on_last_unsafe = last_unsafe && (unsafe_oh == itlb_hit_vec_i);

  // Normally only the hit entry is written
  // On the last unmarked entry, all bits reload from the hit vector
  always_comb begin
    if (!access_hit) begin
      safe_en = '0;
    end else if (hit_on_last_unsafe) begin
      safe_en = '1;
    end else begin
      safe_en = itlb_hit_vec_i;
    end
  end

  // Used bits, one enable per flop
  // Flush of the array leaves them alone
  for (genvar k = 0; k < N; k++) begin : gen_safe
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        safe_q[k] <= 1'b0;
      end else if (safe_en[k]) begin
        safe_q[k] <= itlb_hit_vec_i[k];
      end
    end
  end

  // Invalid slots first, NRU victim once the array is full
  assign itlb_replacement_vec_o = (&itlb_valid_vec_i) ? unsafe_oh : invalid_oh;

endmodule

`default_nettype wire

/* logic/itlb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itlb_config.svh"

// Instruction TLB top level
// Combinational lookup, refill from the walker, flush of all entries
module itlb (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Lookup request
  input  logic         req_valid_i,
  input  vm_pkg::vpn_t req_vpn_i,
  // Lookup result, same cycle
  output logic         hit_o,
  output vm_pkg::ppn_t ppn_o,
  output logic         user_o,
  // Refill from the page-table walker
  input  logic         refill_valid_i,
  input  vm_pkg::vpn_t refill_vpn_i,
  input  vm_pkg::ppn_t refill_ppn_i,
  input  logic         refill_user_i,
  // Invalidate everything
  input  logic         flush_i
);

  vm_pkg::vpn_t       entry_tag [`ITLB_ENTRIES];
  vm_pkg::ppn_t       entry_ppn [`ITLB_ENTRIES];
  itlb_pkg::way_vec_t entry_user;
  itlb_pkg::way_vec_t entry_valid;
  itlb_pkg::way_vec_t hit_vec;
  itlb_pkg::way_vec_t repl_vec;

  // Translation storage
  itlb_entry_array u_entry_array (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .refill_valid_i (refill_valid_i),
    .refill_vpn_i   (refill_vpn_i),
    .refill_ppn_i   (refill_ppn_i),
    .refill_user_i  (refill_user_i),
    .refill_way_i   (repl_vec),
    .flush_i        (flush_i),
    .tag_o          (entry_tag),
    .ppn_o          (entry_ppn),
    .user_o         (entry_user),
    .valid_o        (entry_valid)
  );

  // Parallel compare and result mux
  itlb_lookup u_lookup (
    .req_valid_i (req_valid_i),
    .req_vpn_i   (req_vpn_i),
    .tag_i       (entry_tag),
    .ppn_i       (entry_ppn),
    .user_i      (entry_user),
    .valid_i     (entry_valid),
    .hit_vec_o   (hit_vec),
    .hit_o       (hit_o),
    .ppn_o       (ppn_o),
    .user_o      (user_o)
  );

  // Victim selection, fed back as the refill write select
  itlb_replacement_block #(
    .N (`ITLB_ENTRIES)
  ) u_replacement (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .itlb_valid_vec_i       (entry_valid),
    .itlb_req_valid_i       (req_valid_i),
    .itlb_hit_vec_i         (hit_vec),
    .itlb_hit_i             (hit_o),
    .itlb_replacement_vec_o (repl_vec)
  );

endmodule

`default_nettype wire

/* verif/itlb_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "itlb_config.svh"

// Directed testbench for the instruction TLB
// A reference model mirrors tags, payloads, valid bits and NRU marks
module itlb_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int NUM_TESTS    = 6;
  localparam int RESET_CYCLES = 5;
  // 200 cycles per test plus the reset
  localparam int TIMEOUT_NS   = (NUM_TESTS * 200 + RESET_CYCLES) * CLK_PERIOD;

  logic         clk_i;
  logic         rst_ni;
  logic         req_valid_i;
  vm_pkg::vpn_t req_vpn_i;
  logic         hit_o;
  vm_pkg::ppn_t ppn_o;
  logic         user_o;
  logic         refill_valid_i;
  vm_pkg::vpn_t refill_vpn_i;
  vm_pkg::ppn_t refill_ppn_i;
  logic         refill_user_i;
  logic         flush_i;

  // Reference model of the array and the NRU marks
  vm_pkg::vpn_t       m_tag [`ITLB_ENTRIES];
  vm_pkg::ppn_t       m_ppn [`ITLB_ENTRIES];
  itlb_pkg::way_vec_t m_user;
  itlb_pkg::way_vec_t m_valid;
  itlb_pkg::way_vec_t m_used;

  integer       seed;
  int           err_count;
  int           check_count;
  int           test_count;
  // Every VPN handed out so far, keeps new ones distinct
  vm_pkg::vpn_t seen_vpn [$];
  vm_pkg::vpn_t fill_vpn [`ITLB_ENTRIES];

  itlb dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_vpn_i      (req_vpn_i),
    .hit_o          (hit_o),
    .ppn_o          (ppn_o),
    .user_o         (user_o),
    .refill_valid_i (refill_valid_i),
    .refill_vpn_i   (refill_vpn_i),
    .refill_ppn_i   (refill_ppn_i),
    .refill_user_i  (refill_user_i),
    .flush_i        (flush_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  task automatic fresh_vpn(output vm_pkg::vpn_t vpn);
    logic [31:0] r;
    logic        clash;
    do begin
      r = $random(seed);
      vpn = r[`ITLB_VPN_W-1:0];
      clash = 1'b0;
      foreach (seen_vpn[i]) begin
        if (seen_vpn[i] == vpn) begin
          clash = 1'b1;
        end
      end
    end while (clash);
    seen_vpn.push_back(vpn);
  endtask

  // Index of the valid entry holding vpn, -1 on a miss
  function automatic int find_entry(input vm_pkg::vpn_t vpn);
    int idx;
    idx = -1;
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      if (m_valid[k] && m_tag[k] == vpn) begin
        idx = k;
      end
    end
    return idx;
  endfunction

  // Lowest invalid entry, else lowest entry not recently used
  function automatic int pick_victim();
    int idx;
    idx = -1;
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      if (!m_valid[k] && idx < 0) begin
        idx = k;
      end
    end
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      if (!m_used[k] && idx < 0) begin
        idx = k;
      end
    end
    return (idx < 0) ? 0 : idx;
  endfunction

  // A hit on the last unmarked entry leaves only its own mark
  task automatic mark_used(input int idx);
    logic others_unmarked;
    others_unmarked = 1'b0;
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      if (k != idx && !m_used[k]) begin
        others_unmarked = 1'b1;
      end
    end
    if (!m_used[idx] && !others_unmarked) begin
      m_used = '0;
    end
    m_used[idx] = 1'b1;
  endtask

  // All inputs change together on the rising edge
  task automatic drive(input logic req_v, input vm_pkg::vpn_t req_vpn, input logic ref_v,
                       input vm_pkg::vpn_t ref_vpn, input vm_pkg::ppn_t ref_ppn,
                       input logic ref_user, input logic flush);
    @(posedge clk_i);
    req_valid_i    <= req_v;
    req_vpn_i      <= req_vpn;
    refill_valid_i <= ref_v;
    refill_vpn_i   <= ref_vpn;
    refill_ppn_i   <= ref_ppn;
    refill_user_i  <= ref_user;
    flush_i        <= flush;
  endtask

  task automatic idle();
    vm_pkg::vpn_t vpn;
    vpn = '0;
    // Present a held VPN without a request
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      if (m_valid[k]) begin
        vpn = m_tag[k];
      end
    end
    drive(1'b0, vpn, 1'b0, '0, '0, 1'b0, 1'b0);
    @(negedge clk_i);
    check_value(64'(hit_o), 64'(0), "hit_o without a request");
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    m_valid = '0;
    m_used  = '0;
  endtask

  // Outputs are sampled mid-cycle, against the model's prediction
  task automatic compare_result(input vm_pkg::vpn_t vpn, input int idx);
    logic         exp_hit;
    vm_pkg::ppn_t exp_ppn;
    logic         exp_user;
    exp_hit  = (idx >= 0);
    exp_ppn  = '0;
    exp_user = 1'b0;
    if (exp_hit) begin
      exp_ppn  = m_ppn[idx];
      exp_user = m_user[idx];
    end
    check_value(64'(hit_o), 64'(exp_hit), $sformatf("hit_o for vpn %0h", vpn));
    check_value(64'(ppn_o), 64'(exp_ppn), $sformatf("ppn_o for vpn %0h", vpn));
    check_value(64'(user_o), 64'(exp_user), $sformatf("user_o for vpn %0h", vpn));
  endtask

  task automatic lookup(input vm_pkg::vpn_t vpn);
    int idx;
    drive(1'b1, vpn, 1'b0, '0, '0, 1'b0, 1'b0);
    @(negedge clk_i);
    idx = find_entry(vpn);
    compare_result(vpn, idx);
    // Marks move on the coming edge
    if (idx >= 0) begin
      mark_used(idx);
    end
  endtask

  task automatic write_entry(input int idx, input vm_pkg::vpn_t vpn, input vm_pkg::ppn_t ppn,
                             input logic user);
    m_tag[idx]   = vpn;
    m_ppn[idx]   = ppn;
    m_user[idx]  = user;
    m_valid[idx] = 1'b1;
  endtask

  // Walker refill of a new VPN, always after a miss
  task automatic refill_random(output vm_pkg::vpn_t vpn, output int victim);
    vm_pkg::ppn_t ppn;
    logic [63:0]  r;
    fresh_vpn(vpn);
    r = {$random(seed), $random(seed)};
    ppn = r[`ITLB_PPN_W-1:0];
    lookup(vpn);
    drive(1'b0, '0, 1'b1, vpn, ppn, r[`ITLB_PPN_W], 1'b0);
    @(negedge clk_i);
    victim = pick_victim();
    write_entry(victim, vpn, ppn, r[`ITLB_PPN_W]);
  endtask

  // Fill an empty array, slots taken in index order
  task automatic fill_entries();
    int victim;
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      refill_random(fill_vpn[k], victim);
    end
  endtask

  // Evicted VPN misses, every held VPN hits
  task automatic check_contents(input vm_pkg::vpn_t evicted);
    vm_pkg::vpn_t held [`ITLB_ENTRIES];
    lookup(evicted);
    check_value(64'(hit_o), 64'(0), "hit_o for the evicted vpn");
    held = m_tag;
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      lookup(held[k]);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d mismatches", name, err_count - errs_before);
    end
  endtask

  task automatic reset_miss();
    int           errs;
    vm_pkg::vpn_t vpn;
    errs = err_count;
    apply_reset();
    for (int k = 0; k < 3; k++) begin
      fresh_vpn(vpn);
      lookup(vpn);
      check_value(64'(ppn_o), 64'(0), "ppn_o after reset");
    end
    idle();
    finish_test("reset_miss", errs);
  endtask

  task automatic fill_invalid();
    int errs;
    errs = err_count;
    fill_entries();
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      lookup(fill_vpn[k]);
    end
    idle();
    finish_test("fill_invalid", errs);
  endtask

  // Full array with no marks, the fifth refill takes entry 0
  task automatic evict_lowest();
    int           errs;
    int           victim;
    vm_pkg::vpn_t vpn;
    errs = err_count;
    apply_reset();
    fill_entries();
    refill_random(vpn, victim);
    check_contents(fill_vpn[0]);
    idle();
    finish_test("evict_lowest", errs);
  endtask

  task automatic nru_marks();
    int           errs;
    int           victim;
    vm_pkg::vpn_t vpn;
    vm_pkg::vpn_t old;
    errs = err_count;
    apply_reset();
    fill_entries();
    lookup(fill_vpn[0]);
    lookup(fill_vpn[1]);
    refill_random(vpn, victim);
    lookup(fill_vpn[2]);
    check_value(64'(hit_o), 64'(0), "hit_o for the evicted vpn");
    // Entry 2 then entry 3, the last unmarked one
    lookup(vpn);
    lookup(fill_vpn[3]);
    old = m_tag[pick_victim()];
    refill_random(vpn, victim);
    check_contents(old);
    idle();
    finish_test("nru_marks", errs);
  endtask

  task automatic flush_all();
    int           errs;
    int           victim;
    vm_pkg::vpn_t prev [`ITLB_ENTRIES];
    vm_pkg::vpn_t vpn;
    vm_pkg::vpn_t old;
    errs = err_count;
    prev = m_tag;
    drive(1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b1);
    @(negedge clk_i);
    m_valid = '0;
    for (int k = 0; k < `ITLB_ENTRIES; k++) begin
      lookup(prev[k]);
    end
    fill_entries();
    // Hits on entries 0 and 1 only
    lookup(fill_vpn[0]);
    lookup(fill_vpn[1]);
    // Marks kept over the flush decide the victim
    old = m_tag[pick_victim()];
    refill_random(vpn, victim);
    check_contents(old);
    idle();
    finish_test("flush_all", errs);
  endtask

  task automatic same_cycle_refill();
    int           errs;
    int           victim;
    vm_pkg::vpn_t vpn;
    errs = err_count;
    fresh_vpn(vpn);
    drive(1'b1, vpn, 1'b1, vpn, 44'h5a5_0000_1234, 1'b1, 1'b0);
    @(negedge clk_i);
    // Lookup sees the contents before the write
    compare_result(vpn, find_entry(vpn));
    check_value(64'(hit_o), 64'(0), "hit_o during refill of the same vpn");
    victim = pick_victim();
    write_entry(victim, vpn, 44'h5a5_0000_1234, 1'b1);
    lookup(vpn);
    check_value(64'(hit_o), 64'(1), "hit_o one cycle after refill");
    idle();
    finish_test("same_cycle_refill", errs);
  endtask

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

  initial begin
    seed           = 32'h6ea2;
    err_count      = 0;
    check_count    = 0;
    test_count     = 0;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_vpn_i      = '0;
    refill_valid_i = 1'b0;
    refill_vpn_i   = '0;
    refill_ppn_i   = '0;
    refill_user_i  = 1'b0;
    flush_i        = 1'b0;
    m_valid        = '0;
    m_used         = '0;
    reset_miss();
    fill_invalid();
    evict_lowest();
    nru_marks();
    flush_all();
    same_cycle_refill();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
logic/vm_pkg.sv
logic/itlb_pkg.sv
logic/itlb_entry_array.sv
logic/itlb_lookup.sv
logic/itlb_replacement_block.sv
logic/itlb.sv
verif/itlb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ITLB testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/100ps --top-module itlb_tb \
  -f tb.f -o itlb_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/itlb_sim > sim.log 2>&1
cat sim.log

# The log decides the result
grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
